// File: bus_pkg.sv
package bus_pkg;

  // Wishbone data path is one 32-bit word
  localparam int WB_DATA_W = 32;

  // One select line per byte lane
  localparam int WB_SEL_W = WB_DATA_W / 8;

  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [WB_SEL_W-1:0]  wb_sel_t;

endpackage

// File: mem_access_pkg.sv
package mem_access_pkg;

  // Access width as decoded by the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // Reported together with the end of an access
  typedef enum logic [1:0] {
    FAULT_NONE       = 2'd0,
    FAULT_MISALIGNED = 2'd1,
    FAULT_BUS        = 2'd2
  } fault_e;

  // Halfwords on even offsets, words on offset zero, bytes anywhere
  function automatic logic is_aligned(input access_size_e size, input logic [1:0] offset);
    logic ok;
    case (size)
      SIZE_BYTE: ok = 1'b1;
      SIZE_HALF: ok = ~offset[0];
      SIZE_WORD: ok = (offset == 2'b00);
      default:   ok = 1'b0;
    endcase
    return ok;
  endfunction

endpackage

// File: wb_master.sv
`timescale 1ns/1ns

module wb_master
  import bus_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  wb_data_t          wdata_i,
  input  wb_sel_t           sel_i,
  input  wb_data_t          dat_i,
  input  logic              ack_i,
  input  logic              err_i,
  output logic              cyc_o,
  output logic              stb_o,
  output logic              we_o,
  output logic [ADDR_W-1:0] adr_o,
  output wb_data_t          dat_o,
  output wb_sel_t           sel_o,
  output wb_data_t          rdata_o,
  output logic              done_o,
  output logic              err_o,
  output logic              busy_o
);

  typedef enum logic {
    ST_IDLE,
    ST_XFER
  } state_e;

  state_e            state_q;
  logic [ADDR_W-1:0] adr_q;
  wb_data_t          dat_q;
  wb_sel_t           sel_q;
  logic              we_q;
  wb_data_t          rdata_q;
  logic              done_q;
  logic              err_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_XFER;
          end
        end
        ST_XFER: begin
          // Ack wins if a slave raises both
          if (ack_i) begin
            done_q  <= 1'b1;
            state_q <= ST_IDLE;
          end else if (err_i) begin
            err_q   <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request fields held for the whole transfer
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && req_i) begin
      adr_q <= addr_i;
      dat_q <= wdata_i;
      sel_q <= sel_i;
      we_q  <= we_i;
    end
    if (state_q == ST_XFER && ack_i) begin
      rdata_q <= dat_i;
    end
  end

  // Strobe simply held through wait states
  assign cyc_o   = (state_q == ST_XFER);
  assign stb_o   = (state_q == ST_XFER);
  assign we_o    = (state_q == ST_XFER) & we_q;
  assign adr_o   = adr_q;
  assign dat_o   = dat_q;
  assign sel_o   = sel_q;
  assign rdata_o = rdata_q;
  assign done_o  = done_q;
  assign err_o   = err_q;
  assign busy_o  = (state_q == ST_XFER);

endmodule

// File: fetch_port.sv
`timescale 1ns/1ns

module fetch_port
  import bus_pkg::*, mem_access_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_req_i,
  input  logic [ADDR_W-1:0] pc_i,
  output wb_data_t          instr_o,
  output logic              instr_valid_o,
  output logic              fetch_stall_o,
  output fault_e            fetch_fault_o,
  output logic              i_cyc_o,
  output logic              i_stb_o,
  output logic [ADDR_W-1:0] i_adr_o,
  output wb_sel_t           i_sel_o,
  input  wb_data_t          i_dat_i,
  input  logic              i_ack_i,
  input  logic              i_err_i
);

  logic     pending_q;
  logic     misalign_q;
  logic     accept;
  logic     pc_ok;
  logic     m_done;
  logic     m_err;
  wb_data_t instr_q;

  assign accept = fetch_req_i & ~pending_q;
  assign pc_ok  = (pc_i[1:0] == 2'b00);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q  <= 1'b0;
      misalign_q <= 1'b0;
    end else begin
      misalign_q <= accept & ~pc_ok;
      if (accept) begin
        pending_q <= 1'b1;
      end else if (instr_valid_o) begin
        pending_q <= 1'b0;
      end
    end
  end

  // Instruction register, kept until the next fetch returns
  always_ff @(posedge clk) begin
    if (i_cyc_o && i_ack_i) begin
      instr_q <= i_dat_i;
    end
  end

  wb_master #(
    .ADDR_W (ADDR_W)
  ) u_wb_master (
    .clk     (clk),
    .rst     (rst),
    .req_i   (accept & pc_ok),
    .we_i    (1'b0),
    .addr_i  (pc_i),
    .wdata_i ('0),
    .sel_i   ({WB_SEL_W{1'b1}}),
    .dat_i   (i_dat_i),
    .ack_i   (i_ack_i),
    .err_i   (i_err_i),
    .cyc_o   (i_cyc_o),
    .stb_o   (i_stb_o),
    .we_o    (),
    .adr_o   (i_adr_o),
    .dat_o   (),
    .sel_o   (i_sel_o),
    .rdata_o (),
    .done_o  (m_done),
    .err_o   (m_err),
    .busy_o  ()
  );

  // Every fetch ends with a valid pulse, faulted or not
  assign instr_valid_o = misalign_q | m_done | m_err;
  assign fetch_stall_o = accept | pending_q;
  assign instr_o       = instr_q;

  always_comb begin
    if (misalign_q) begin
      fetch_fault_o = FAULT_MISALIGNED;
    end else if (m_err) begin
      fetch_fault_o = FAULT_BUS;
    end else begin
      fetch_fault_o = FAULT_NONE;
    end
  end

endmodule

// File: data_align.sv
`timescale 1ns/1ns

module data_align
  import bus_pkg::*, mem_access_pkg::*;
(
  input  access_size_e size_i,
  input  logic [1:0]   offset_i,
  input  logic         unsigned_i,
  input  wb_data_t     store_data_i,
  input  wb_data_t     load_word_i,
  output wb_data_t     store_word_o,
  output wb_sel_t      sel_o,
  output wb_data_t     load_data_o
);

  wb_data_t load_shifted;
  logic     byte_sign;
  logic     half_sign;

  // Store side, data copied to every lane and the selects pick the lanes
  always_comb begin
    case (size_i)
      SIZE_BYTE: begin
        store_word_o = {4{store_data_i[7:0]}};
        sel_o        = wb_sel_t'(4'b0001) << offset_i;
      end
      SIZE_HALF: begin
        store_word_o = {2{store_data_i[15:0]}};
        sel_o        = wb_sel_t'(4'b0011) << offset_i;
      end
      default: begin
        store_word_o = store_data_i;
        sel_o        = '1;
      end
    endcase
  end

  // Load side, addressed lane moved down to bit zero
  assign load_shifted = load_word_i >> {offset_i, 3'b000};
  assign byte_sign    = ~unsigned_i & load_shifted[7];
  assign half_sign    = ~unsigned_i & load_shifted[15];

  always_comb begin
    case (size_i)
      SIZE_BYTE: load_data_o = {{24{byte_sign}}, load_shifted[7:0]};
      SIZE_HALF: load_data_o = {{16{half_sign}}, load_shifted[15:0]};
      default:   load_data_o = load_word_i;
    endcase
  end

endmodule

// File: data_port.sv
`timescale 1ns/1ns

module data_port
  import bus_pkg::*, mem_access_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_read_i,
  input  logic              mem_write_i,
  input  access_size_e      mem_size_i,
  input  logic              mem_unsigned_i,
  input  logic [ADDR_W-1:0] mem_addr_i,
  input  wb_data_t          mem_wdata_i,
  output wb_data_t          mem_rdata_o,
  output logic              mem_done_o,
  output logic              mem_stall_o,
  output fault_e            mem_fault_o,
  output logic              d_cyc_o,
  output logic              d_stb_o,
  output logic              d_we_o,
  output logic [ADDR_W-1:0] d_adr_o,
  output wb_data_t          d_dat_o,
  output wb_sel_t           d_sel_o,
  input  wb_data_t          d_dat_i,
  input  logic              d_ack_i,
  input  logic              d_err_i
);

  logic              pending_q;
  logic              misalign_q;
  access_size_e      size_q;
  logic [1:0]        offset_q;
  logic              unsigned_q;
  logic              any_req;
  logic              accept;
  logic              addr_ok;
  access_size_e      align_size;
  logic [1:0]        align_offset;
  logic [ADDR_W-1:0] word_addr;
  wb_data_t          store_word;
  wb_sel_t           store_sel;
  wb_data_t          bus_rdata;
  logic              m_done;
  logic              m_err;

  // Exactly one of read or write starts an access
  assign any_req   = mem_read_i ^ mem_write_i;
  assign accept    = any_req & ~pending_q;
  assign addr_ok   = is_aligned(mem_size_i, mem_addr_i[1:0]);
  assign word_addr = {mem_addr_i[ADDR_W-1:2], 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q  <= 1'b0;
      misalign_q <= 1'b0;
    end else begin
      misalign_q <= accept & ~addr_ok;
      if (accept) begin
        pending_q <= 1'b1;
      end else if (mem_done_o) begin
        pending_q <= 1'b0;
      end
    end
  end

  // Access shape for load extraction at the end of the transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      size_q     <= mem_size_i;
      offset_q   <= mem_addr_i[1:0];
      unsigned_q <= mem_unsigned_i;
    end
  end

  // Live request steers the store, captured shape extracts the load
  assign align_size   = pending_q ? size_q : mem_size_i;
  assign align_offset = pending_q ? offset_q : mem_addr_i[1:0];

  data_align u_data_align (
    .size_i       (align_size),
    .offset_i     (align_offset),
    .unsigned_i   (unsigned_q),
    .store_data_i (mem_wdata_i),
    .load_word_i  (bus_rdata),
    .store_word_o (store_word),
    .sel_o        (store_sel),
    .load_data_o  (mem_rdata_o)
  );

  wb_master #(
    .ADDR_W (ADDR_W)
  ) u_wb_master (
    .clk     (clk),
    .rst     (rst),
    .req_i   (accept & addr_ok),
    .we_i    (mem_write_i),
    .addr_i  (word_addr),
    .wdata_i (store_word),
    .sel_i   (store_sel),
    .dat_i   (d_dat_i),
    .ack_i   (d_ack_i),
    .err_i   (d_err_i),
    .cyc_o   (d_cyc_o),
    .stb_o   (d_stb_o),
    .we_o    (d_we_o),
    .adr_o   (d_adr_o),
    .dat_o   (d_dat_o),
    .sel_o   (d_sel_o),
    .rdata_o (bus_rdata),
    .done_o  (m_done),
    .err_o   (m_err),
    .busy_o  ()
  );

  assign mem_done_o  = misalign_q | m_done | m_err;
  assign mem_stall_o = any_req | pending_q;

  always_comb begin
    if (misalign_q) begin
      mem_fault_o = FAULT_MISALIGNED;
    end else if (m_err) begin
      mem_fault_o = FAULT_BUS;
    end else begin
      mem_fault_o = FAULT_NONE;
    end
  end

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit
  import bus_pkg::*, mem_access_pkg::*;
#(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  // Core fetch side
  input  logic              fetch_req_i,
  input  logic [ADDR_W-1:0] pc_i,
  output wb_data_t          instr_o,
  output logic              instr_valid_o,
  output logic              fetch_stall_o,
  output fault_e            fetch_fault_o,
  // Core data side
  input  logic              mem_read_i,
  input  logic              mem_write_i,
  input  access_size_e      mem_size_i,
  input  logic              mem_unsigned_i,
  input  logic [ADDR_W-1:0] mem_addr_i,
  input  wb_data_t          mem_wdata_i,
  output wb_data_t          mem_rdata_o,
  output logic              mem_done_o,
  output logic              mem_stall_o,
  output fault_e            mem_fault_o,
  // Instruction bus
  output logic              i_cyc_o,
  output logic              i_stb_o,
  output logic [ADDR_W-1:0] i_adr_o,
  output wb_sel_t           i_sel_o,
  input  wb_data_t          i_dat_i,
  input  logic              i_ack_i,
  input  logic              i_err_i,
  // Data bus
  output logic              d_cyc_o,
  output logic              d_stb_o,
  output logic              d_we_o,
  output logic [ADDR_W-1:0] d_adr_o,
  output wb_data_t          d_dat_o,
  output wb_sel_t           d_sel_o,
  input  wb_data_t          d_dat_i,
  input  logic              d_ack_i,
  input  logic              d_err_i
);

  fetch_port #(
    .ADDR_W (ADDR_W)
  ) u_fetch_port (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req_i),
    .pc_i          (pc_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .fetch_stall_o (fetch_stall_o),
    .fetch_fault_o (fetch_fault_o),
    .i_cyc_o       (i_cyc_o),
    .i_stb_o       (i_stb_o),
    .i_adr_o       (i_adr_o),
    .i_sel_o       (i_sel_o),
    .i_dat_i       (i_dat_i),
    .i_ack_i       (i_ack_i),
    .i_err_i       (i_err_i)
  );

  data_port #(
    .ADDR_W (ADDR_W)
  ) u_data_port (
    .clk            (clk),
    .rst            (rst),
    .mem_read_i     (mem_read_i),
    .mem_write_i    (mem_write_i),
    .mem_size_i     (mem_size_i),
    .mem_unsigned_i (mem_unsigned_i),
    .mem_addr_i     (mem_addr_i),
    .mem_wdata_i    (mem_wdata_i),
    .mem_rdata_o    (mem_rdata_o),
    .mem_done_o     (mem_done_o),
    .mem_stall_o    (mem_stall_o),
    .mem_fault_o    (mem_fault_o),
    .d_cyc_o        (d_cyc_o),
    .d_stb_o        (d_stb_o),
    .d_we_o         (d_we_o),
    .d_adr_o        (d_adr_o),
    .d_dat_o        (d_dat_o),
    .d_sel_o        (d_sel_o),
    .d_dat_i        (d_dat_i),
    .d_ack_i        (d_ack_i),
    .d_err_i        (d_err_i)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: wb_mem_model.sv
`timescale 1ns/1ns

module wb_mem_model
  import bus_pkg::*;
#(
  parameter int          ADDR_W   = 32,
  parameter int          DEPTH    = 1024,
  parameter logic [31:0] SEED     = 32'd1,
  parameter logic [31:0] FILL_KEY = 32'h0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  wb_data_t          dat_i,
  input  wb_sel_t           sel_i,
  output wb_data_t          dat_o,
  output logic              ack_o,
  output logic              err_o
);

  localparam int IDX_W = $clog2(DEPTH);

  wb_data_t          mem [DEPTH];
  wb_data_t          dat_q    = '0;
  logic              ack_q    = 1'b0;
  logic              err_q    = 1'b0;
  logic              active_q = 1'b0;
  logic [1:0]        wait_q   = 2'd0;
  logic [31:0]       rnd_q    = SEED;
  logic [1:0]        waits;
  logic              in_range;
  logic [IDX_W-1:0]  idx;

  function automatic logic [31:0] next_draw(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Contents depend on the whole word index
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b1) ^ FILL_KEY;
    end
  end

  // Fresh draw on the first strobe cycle, countdown after that
  assign waits    = active_q ? wait_q : rnd_q[1:0];
  assign in_range = adr_i[ADDR_W-1:2] < (ADDR_W-2)'(DEPTH);
  assign idx      = adr_i[IDX_W+1:2];

  always @(posedge clk) begin
    if (rst) begin
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      active_q <= 1'b0;
      wait_q   <= 2'd0;
      rnd_q    <= SEED;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      // No new transfer while the last answer is still on the bus
      if (cyc_i && stb_i && !ack_q && !err_q) begin
        if (!active_q) begin
          rnd_q <= next_draw(rnd_q);
        end
        if (waits != 2'd0) begin
          active_q <= 1'b1;
          wait_q   <= waits - 2'd1;
        end else begin
          active_q <= 1'b0;
          if (!in_range) begin
            err_q <= 1'b1;
          end else begin
            ack_q <= 1'b1;
            if (we_i) begin
              for (int b = 0; b < WB_SEL_W; b++) begin
                if (sel_i[b]) mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
              end
            end else begin
              dat_q <= mem[idx];
            end
          end
        end
      end
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule

// File: tb_load_store_unit.sv
`timescale 1ns/1ns

module tb_load_store_unit
  import bus_pkg::*, mem_access_pkg::*;
();

  typedef enum logic [1:0] {KIND_FETCH, KIND_LOAD, KIND_STORE} kind_e;

  typedef struct packed {
    kind_e        kind;
    logic [31:0]  addr;
    access_size_e size;
    logic         uns;
    logic [31:0]  wdata;
    fault_e       fault;
  } entry_t;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] idx, input logic [31:0] key);
    return (idx * 32'h9e37_79b1) ^ key;
  endfunction

  // Addressed byte or halfword, then sign or zero extended to a word
  function automatic logic [31:0] expected_load(input logic [31:0] word, input logic [1:0] off,
                                                input access_size_e size, input logic uns);
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic [31:0] result;
    lane_byte = word[8*int'(off) +: 8];
    lane_half = off[1] ? word[31:16] : word[15:0];
    case (size)
      SIZE_BYTE: begin
        if (!uns && lane_byte[7]) begin
          result = {24'hff_ffff, lane_byte};
        end else begin
          result = {24'h00_0000, lane_byte};
        end
      end
      SIZE_HALF: begin
        if (!uns && lane_half[15]) begin
          result = {16'hffff, lane_half};
        end else begin
          result = {16'h0000, lane_half};
        end
      end
      default: result = word;
    endcase
    return result;
  endfunction

  localparam logic [31:0] ISEED = xorshift32(32'd65);
  localparam logic [31:0] DSEED = xorshift32(ISEED);
  localparam logic [31:0] IKEY  = 32'h1357_9bdf;
  localparam logic [31:0] DKEY  = 32'h2468_ace0;

  logic         clk;
  logic         rst;
  logic         fetch_req_i;
  logic [31:0]  pc_i;
  wb_data_t     instr_o;
  logic         instr_valid_o;
  logic         fetch_stall_o;
  fault_e       fetch_fault_o;
  logic         mem_read_i;
  logic         mem_write_i;
  access_size_e mem_size_i;
  logic         mem_unsigned_i;
  logic [31:0]  mem_addr_i;
  wb_data_t     mem_wdata_i;
  wb_data_t     mem_rdata_o;
  logic         mem_done_o;
  logic         mem_stall_o;
  fault_e       mem_fault_o;
  logic         i_cyc_o;
  logic         i_stb_o;
  logic [31:0]  i_adr_o;
  wb_sel_t      i_sel_o;
  wb_data_t     i_dat_i;
  logic         i_ack_i;
  logic         i_err_i;
  logic         d_cyc_o;
  logic         d_stb_o;
  logic         d_we_o;
  logic [31:0]  d_adr_o;
  wb_data_t     d_dat_o;
  wb_sel_t      d_sel_o;
  wb_data_t     d_dat_i;
  logic         d_ack_i;
  logic         d_err_i;

  entry_t       entries[$];
  logic [31:0]  ref_mem [1024];
  int           check_count = 0;
  int           error_count = 0;
  int           cycle_count = 0;
  int           cycle_limit = 0;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clk_gen (.clk_o(clk), .rst_o(rst));

  load_store_unit #(.ADDR_W(32)) u_dut (.*);

  wb_mem_model #(.SEED(ISEED), .FILL_KEY(IKEY)) u_imem (
    .clk(clk), .rst(rst), .cyc_i(i_cyc_o), .stb_i(i_stb_o), .we_i(1'b0), .adr_i(i_adr_o),
    .dat_i('0), .sel_i(i_sel_o), .dat_o(i_dat_i), .ack_o(i_ack_i), .err_o(i_err_i)
  );

  wb_mem_model #(.SEED(DSEED), .FILL_KEY(DKEY)) u_dmem (
    .clk(clk), .rst(rst), .cyc_i(d_cyc_o), .stb_i(d_stb_o), .we_i(d_we_o), .adr_i(d_adr_o),
    .dat_i(d_dat_o), .sel_i(d_sel_o), .dat_o(d_dat_i), .ack_o(d_ack_i), .err_o(d_err_i)
  );

  task automatic compare_value(input logic [31:0] got, input logic [31:0] want, input string what);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("Mismatch at %0t ns: %s, got %08h, expected %08h", $time, what, got, want);
    end
  endtask

  task automatic add_entry(input kind_e k, input logic [31:0] a, input access_size_e s,
                           input logic u, input logic [31:0] w, input fault_e f);
    entry_t e;
    e.kind  = k;
    e.addr  = a;
    e.size  = s;
    e.uns   = u;
    e.wdata = w;
    e.fault = f;
    entries.push_back(e);
  endtask

  // Only lanes covered by the access size change
  task automatic apply_store(input entry_t e);
    int nbytes;
    int lane;
    nbytes = (e.size == SIZE_BYTE) ? 1 : (e.size == SIZE_HALF) ? 2 : 4;
    for (int b = 0; b < 4; b++) begin
      lane = b - int'(e.addr[1:0]);
      if (lane >= 0 && lane < nbytes) ref_mem[e.addr[11:2]][8*b +: 8] = e.wdata[8*lane +: 8];
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    rnd = DSEED;
    // Fetches, then misaligned and out of range pc values
    add_entry(KIND_FETCH, 32'h0000, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_FETCH, 32'h0004, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_FETCH, 32'h0ffc, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_FETCH, 32'h0102, SIZE_WORD, 1'b0, '0, FAULT_MISALIGNED);
    add_entry(KIND_FETCH, 32'h0001, SIZE_WORD, 1'b0, '0, FAULT_MISALIGNED);
    add_entry(KIND_FETCH, 32'h1000, SIZE_WORD, 1'b0, '0, FAULT_BUS);
    add_entry(KIND_FETCH, 32'h0100, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_LOAD,  32'h0200, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_STORE, 32'h0200, SIZE_WORD, 1'b0, 32'h80ff_7f01, FAULT_NONE);
    add_entry(KIND_LOAD,  32'h0200, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    // Byte stores at every offset
    add_entry(KIND_STORE, 32'h0204, SIZE_BYTE, 1'b0, 32'h0000_00a1, FAULT_NONE);
    add_entry(KIND_STORE, 32'h0206, SIZE_BYTE, 1'b0, 32'hffff_ff7e, FAULT_NONE);
    add_entry(KIND_LOAD,  32'h0204, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_STORE, 32'h0205, SIZE_BYTE, 1'b0, 32'h1234_5690, FAULT_NONE);
    add_entry(KIND_STORE, 32'h0207, SIZE_BYTE, 1'b0, 32'h0000_0033, FAULT_NONE);
    add_entry(KIND_LOAD,  32'h0204, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_STORE, 32'h020a, SIZE_HALF, 1'b0, 32'hdead_8001, FAULT_NONE);
    add_entry(KIND_LOAD,  32'h0208, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    add_entry(KIND_STORE, 32'h0208, SIZE_HALF, 1'b0, 32'h0000_7ffe, FAULT_NONE);
    add_entry(KIND_LOAD,  32'h0208, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    // Signed and unsigned lanes
    for (int off = 0; off < 4; off++) begin
      add_entry(KIND_LOAD, 32'h0200 + 32'(off), SIZE_BYTE, 1'b0, '0, FAULT_NONE);
      add_entry(KIND_LOAD, 32'h0200 + 32'(off), SIZE_BYTE, 1'b1, '0, FAULT_NONE);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_entry(KIND_LOAD, 32'h0200 + 32'(off), SIZE_HALF, 1'b0, '0, FAULT_NONE);
      add_entry(KIND_LOAD, 32'h0200 + 32'(off), SIZE_HALF, 1'b1, '0, FAULT_NONE);
    end
    for (int n = 0; n < 4; n++) begin
      rnd = xorshift32(rnd);
      add_entry(KIND_STORE, {22'd0, rnd[9:2], 2'b00}, SIZE_WORD, 1'b0, rnd, FAULT_NONE);
      add_entry(KIND_LOAD,  {22'd0, rnd[9:2], 2'b00}, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    end
    add_entry(KIND_LOAD,  32'h0201, SIZE_HALF, 1'b0, '0, FAULT_MISALIGNED);
    add_entry(KIND_LOAD,  32'h0202, SIZE_WORD, 1'b0, '0, FAULT_MISALIGNED);
    add_entry(KIND_STORE, 32'h0203, SIZE_WORD, 1'b0, 32'h5555_aaaa, FAULT_MISALIGNED);
    add_entry(KIND_STORE, 32'h0209, SIZE_HALF, 1'b0, 32'h0000_c3c3, FAULT_MISALIGNED);
    add_entry(KIND_LOAD,  32'h0208, SIZE_WORD, 1'b0, '0, FAULT_NONE);
    // Bus errors, then a normal access
    add_entry(KIND_LOAD,  32'h1000, SIZE_WORD, 1'b0, '0, FAULT_BUS);
    add_entry(KIND_STORE, 32'h3ffd, SIZE_BYTE, 1'b0, 32'h0000_0077, FAULT_BUS);
    add_entry(KIND_LOAD,  32'h0200, SIZE_WORD, 1'b0, '0, FAULT_NONE);
  endtask

  task automatic run_entry(input int n, input entry_t e);
    logic        is_fetch;
    logic        done;
    logic [31:0] got_data;
    logic [31:0] want_data;
    fault_e      got_fault;
    is_fetch = (e.kind == KIND_FETCH);
    @(posedge clk);
    if (is_fetch) begin
      fetch_req_i <= 1'b1;
      pc_i        <= e.addr;
    end else begin
      mem_read_i     <= (e.kind == KIND_LOAD);
      mem_write_i    <= (e.kind == KIND_STORE);
      mem_size_i     <= e.size;
      mem_unsigned_i <= e.uns;
      mem_addr_i     <= e.addr;
      mem_wdata_i    <= e.wdata;
    end
    @(negedge clk);
    compare_value(32'(is_fetch ? fetch_stall_o : mem_stall_o), 32'd1,
                  $sformatf("entry %0d stall", n));
    @(posedge clk);
    fetch_req_i <= 1'b0;
    mem_read_i  <= 1'b0;
    mem_write_i <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      compare_value(32'(is_fetch ? fetch_stall_o : mem_stall_o), 32'd1,
                    $sformatf("entry %0d stall", n));
      if (e.fault == FAULT_MISALIGNED) begin
        compare_value(32'(is_fetch ? i_stb_o : d_stb_o), 32'd0, $sformatf("entry %0d strobe", n));
      end
      // Instruction reads always select the whole word
      if (is_fetch && i_stb_o) begin
        compare_value(32'(i_sel_o), 32'h0000_000f, $sformatf("entry %0d fetch select", n));
      end
      done = is_fetch ? instr_valid_o : mem_done_o;
    end
    if (is_fetch) begin
      got_fault = fetch_fault_o;
      got_data  = instr_o;
      want_data = fill_word(e.addr >> 2, IKEY);
    end else begin
      got_fault = mem_fault_o;
      got_data  = mem_rdata_o;
      want_data = expected_load(ref_mem[e.addr[11:2]], e.addr[1:0], e.size, e.uns);
    end
    compare_value(32'(got_fault), 32'(e.fault), $sformatf("entry %0d fault", n));
    if (e.fault == FAULT_NONE && e.kind != KIND_STORE) begin
      compare_value(got_data, want_data, $sformatf("entry %0d read data", n));
    end
    if (e.fault == FAULT_NONE && e.kind == KIND_STORE) apply_store(e);
  endtask

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    fetch_req_i    = 1'b0;
    pc_i           = '0;
    mem_read_i     = 1'b0;
    mem_write_i    = 1'b0;
    mem_size_i     = SIZE_WORD;
    mem_unsigned_i = 1'b0;
    mem_addr_i     = '0;
    mem_wdata_i    = '0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_word(32'(i), DKEY);
    end
    build_table();
    cycle_limit = 40 * entries.size() + 20;
    @(negedge clk);
    while (rst) @(negedge clk);
    // Bus and core outputs quiet after reset
    compare_value(32'({i_cyc_o, i_stb_o, d_cyc_o, d_stb_o, d_we_o, instr_valid_o, mem_done_o,
                       fetch_stall_o, mem_stall_o, fetch_fault_o, mem_fault_o}), 32'd0,
                  "outputs after reset");
    foreach (entries[i]) begin
      run_entry(i, entries[i]);
    end
    @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: vlog.f
bus_pkg.sv
mem_access_pkg.sv
wb_master.sv
fetch_port.sv
data_align.sv
data_port.sv
load_store_unit.sv
tb_clk_gen.sv
wb_mem_model.sv
tb_load_store_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_load_store_unit -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/tb_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' <<< "$output"; then
  exit 0
fi
exit 1
